// ==== src.f ====
design/debug_pkg.sv
design/baud_rate_generator.sv
design/uart_rx.sv
design/uart_tx.sv
design/instruction_memory.sv
design/fetch_unit.sv
design/debug_unit.sv
design/debug_top.sv
tb/tb_debug_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench, exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_debug_top -f src.f \
    -o tb_debug_top && ./obj_dir/tb_debug_top || exit 1

// ==== tb/tb_debug_top.sv ====
`timescale 1ns/100ps

module tb_debug_top
    import debug_pkg::*;
();

    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_CYCLES  = 4;
    localparam int BIT_CLKS      = CLKS_PER_TICK * OVERSAMPLE;
    localparam int CHARS_PER_ROW = 6;
    localparam int BITS_PER_CHAR = 10;
    localparam int RUN_ALLOWANCE = 32;
    // not a valid command byte
    localparam logic [BYTE_W-1:0] UNKNOWN_CMD = 8'h78;

    // one host command with its load payload
    typedef struct packed {
        logic [BYTE_W-1:0] cmd;
        logic [WORD_W-1:0] payload;
        logic              expect_resp;
    } row_t;

    logic i_clock;
    logic i_reset;
    logic i_uart_rx;
    logic o_uart_tx;

    row_t table_q[$];
    bit   table_ready;
    int   seed;

    // reference model of memory, load pointer and pc
    logic [WORD_W-1:0]    model_mem [IM_DEPTH];
    logic [IM_ADDR_W-1:0] model_ptr;
    logic [IM_ADDR_W-1:0] model_pc;

    debug_top dut_i (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_uart_rx (i_uart_rx),
        .o_uart_tx (o_uart_tx)
    );

    initial begin
        i_clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
    end

    task automatic stop_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_problem(input string what);
        $display("ERROR at %0t: %s", $time, what);
        stop_run();
    endtask

    task automatic compare_word(input string name, input logic [WORD_W-1:0] expected,
                                input logic [WORD_W-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name,
                     expected, actual);
            stop_run();
        end
    endtask

    // start bit then 8 data bits lsb first then stop bit
    task automatic send_byte(input logic [BYTE_W-1:0] value);
        logic [BITS_PER_CHAR-1:0] frame;
        int                       i;
        frame = {1'b1, value, 1'b0};
        for (i = 0; i < BITS_PER_CHAR; i++) begin
            @(posedge i_clock);
            #DRIVE_DELAY;
            i_uart_rx = frame[i];
            repeat (BIT_CLKS - 1) @(posedge i_clock);
        end
    endtask

    // sampled on the falling clock near mid-bit
    task automatic receive_byte(output logic [BYTE_W-1:0] value);
        logic [BYTE_W-1:0] bits;
        int                i;
        @(negedge o_uart_tx);
        repeat (BIT_CLKS / 2) @(negedge i_clock);
        if (o_uart_tx !== 1'b0) begin
            report_problem("start bit on o_uart_tx did not stay low until mid-bit");
        end
        for (i = 0; i < BYTE_W; i++) begin
            repeat (BIT_CLKS) @(negedge i_clock);
            bits[i] = o_uart_tx;
        end
        repeat (BIT_CLKS) @(negedge i_clock);
        if (o_uart_tx !== 1'b1) begin
            report_problem("stop bit on o_uart_tx is low");
        end
        value = bits;
    endtask

    // four bytes lsb first
    task automatic check_response(input logic [WORD_W-1:0] expected);
        logic [BYTE_W-1:0] value;
        logic [WORD_W-1:0] word;
        int                k;
        word = '0;
        for (k = 0; k < WORD_BYTES; k++) begin
            receive_byte(value);
            word[k*BYTE_W +: BYTE_W] = value;
        end
        compare_word("o_uart_tx response word", expected, word);
    endtask

    // no start bit allowed in this window
    task automatic expect_line_idle(input int clocks);
        repeat (clocks) begin
            @(negedge i_clock);
            if (o_uart_tx !== 1'b1) begin
                report_problem("o_uart_tx left idle when no response was due");
            end
        end
    endtask

    function automatic logic [WORD_W-1:0] random_load_word();
        logic [WORD_W-1:0] word;
        word = $random(seed);
        // halt word only where placed on purpose
        if (word == HALT_WORD) begin
            word[0] = 1'b0;
        end
        return word;
    endfunction

    function automatic void append_row(input logic [BYTE_W-1:0] cmd,
                                       input logic [WORD_W-1:0] payload,
                                       input logic expect_resp);
        row_t row;
        row.cmd         = cmd;
        row.payload     = payload;
        row.expect_resp = expect_resp;
        table_q.push_back(row);
    endfunction

    task automatic build_table();
        // pc reads zero after reset
        append_row(CMD_PC, '0, 1'b1);
        // eight words then walk them with step
        append_row(CMD_CLEAR, '0, 1'b0);
        repeat (8) append_row(CMD_LOAD, random_load_word(), 1'b0);
        append_row(CMD_INSTR, '0, 1'b1);
        repeat (7) begin
            append_row(CMD_STEP, '0, 1'b0);
            append_row(CMD_INSTR, '0, 1'b1);
        end
        // halt at word 5 so run stops there and step is frozen
        append_row(CMD_CLEAR, '0, 1'b0);
        repeat (5) append_row(CMD_LOAD, random_load_word(), 1'b0);
        append_row(CMD_LOAD, HALT_WORD, 1'b0);
        append_row(CMD_RUN, '0, 1'b1);
        append_row(CMD_STEP, '0, 1'b0);
        append_row(CMD_PC, '0, 1'b1);
        // clear restarts pc and load pointer
        append_row(CMD_CLEAR, '0, 1'b0);
        append_row(CMD_PC, '0, 1'b1);
        append_row(CMD_LOAD, random_load_word(), 1'b0);
        append_row(CMD_INSTR, '0, 1'b1);
        // unknown byte gets no response
        append_row(UNKNOWN_CMD, '0, 1'b0);
        append_row(CMD_PC, '0, 1'b1);
        // 33 loads wrap the pointer onto word 0
        append_row(CMD_CLEAR, '0, 1'b0);
        repeat (IM_DEPTH + 1) append_row(CMD_LOAD, random_load_word(), 1'b0);
        append_row(CMD_INSTR, '0, 1'b1);
        append_row(CMD_STEP, '0, 1'b0);
        append_row(CMD_INSTR, '0, 1'b1);
    endtask

    // update the model and return the response word if any
    task automatic predict_response(input row_t row, output logic [WORD_W-1:0] expected);
        int guard;
        expected = '0;
        guard    = 0;
        case (row.cmd)
            CMD_LOAD: begin
                model_mem[model_ptr] = row.payload;
                model_ptr            = model_ptr + 1'b1;
            end
            CMD_CLEAR: begin
                model_ptr = '0;
                model_pc  = '0;
            end
            CMD_STEP: begin
                if (model_mem[model_pc] !== HALT_WORD) begin
                    model_pc = model_pc + 1'b1;
                end
            end
            CMD_RUN: begin
                while (model_mem[model_pc] !== HALT_WORD) begin
                    if (guard == IM_DEPTH) begin
                        report_problem("run row has no halt word to stop on");
                    end
                    model_pc = model_pc + 1'b1;
                    guard++;
                end
                expected = WORD_W'(model_pc);
            end
            CMD_PC:    expected = WORD_W'(model_pc);
            CMD_INSTR: expected = model_mem[model_pc];
            default:   expected = '0;
        endcase
    endtask

    initial begin
        row_t              row;
        logic [WORD_W-1:0] expected;
        int                k;
        i_reset   = 1'b1;
        i_uart_rx = 1'b1;
        seed      = 32'h8cab;
        model_ptr = '0;
        model_pc  = '0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge i_clock);
        #DRIVE_DELAY;
        i_reset = 1'b0;
        // serial line idles high
        expect_line_idle(BIT_CLKS);
        foreach (table_q[n]) begin
            row = table_q[n];
            predict_response(row, expected);
            if (row.expect_resp) begin
                // response overlaps the command stop bit
                fork
                    send_byte(row.cmd);
                    check_response(expected);
                join
            end else begin
                send_byte(row.cmd);
                if (row.cmd == CMD_LOAD) begin
                    for (k = 0; k < WORD_BYTES; k++) begin
                        send_byte(row.payload[k*BYTE_W +: BYTE_W]);
                    end
                end
                expect_line_idle(BIT_CLKS / 2);
            end
        end
        $display("TEST PASS");
        $finish;
    end

    // budget of six characters plus run time per row
    initial begin
        int limit_clocks;
        wait (table_ready);
        limit_clocks = table_q.size()
                     * (CHARS_PER_ROW * BITS_PER_CHAR * BIT_CLKS + RUN_ALLOWANCE);
        repeat (limit_clocks) @(posedge i_clock);
        report_problem("watchdog expired before the command table finished");
    end

endmodule

// ==== design/debug_top.sv ====
`timescale 1ns/100ps

module debug_top
    import debug_pkg::*;
(
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_uart_rx,
    output logic o_uart_tx
);

    logic                 tick;
    // uart to debug unit
    logic                 rx_done;
    logic [BYTE_W-1:0]    rx_data;
    logic                 tx_start;
    logic [BYTE_W-1:0]    tx_data;
    logic                 tx_busy;
    logic                 tx_done;
    // debug unit to memory
    logic                 im_write_enable;
    logic [IM_ADDR_W-1:0] im_addr;
    logic [WORD_W-1:0]    im_data;
    // fetch control and status
    logic                 step;
    logic                 run;
    logic                 pc_clear;
    logic                 halt;
    logic [IM_ADDR_W-1:0] pc_addr;
    logic [WORD_W-1:0]    pc;
    logic [WORD_W-1:0]    instruction;

    baud_rate_generator baud_rate_generator_1 (.i_clock(i_clock), .i_reset(i_reset),
        .o_tick(tick));

    uart_rx uart_rx_1 (.i_clock(i_clock), .i_reset(i_reset), .i_tick(tick),
        .i_rx(i_uart_rx), .o_rx_data(rx_data), .o_rx_done(rx_done));

    uart_tx uart_tx_1 (.i_clock(i_clock), .i_reset(i_reset), .i_tick(tick),
        .i_tx_start(tx_start), .i_tx_data(tx_data), .o_tx(o_uart_tx),
        .o_tx_busy(tx_busy), .o_tx_done(tx_done));

    debug_unit debug_unit_1 (.i_clock(i_clock), .i_reset(i_reset),
        .i_rx_done(rx_done), .i_rx_data(rx_data), .i_tx_done(tx_done),
        .i_tx_busy(tx_busy), .i_halt(halt), .i_pc(pc), .i_instruction(instruction),
        .o_tx_start(tx_start), .o_tx_data(tx_data), .o_im_write_enable(im_write_enable),
        .o_im_addr(im_addr), .o_im_data(im_data), .o_step(step), .o_run(run),
        .o_pc_clear(pc_clear));

    instruction_memory instruction_memory_1 (.i_clock(i_clock),
        .i_write_enable(im_write_enable), .i_write_addr(im_addr), .i_write_data(im_data),
        .i_read_addr(pc_addr), .o_read_data(instruction));

    fetch_unit fetch_unit_1 (.i_clock(i_clock), .i_reset(i_reset), .i_pc_clear(pc_clear),
        .i_step(step), .i_run(run), .i_instruction(instruction), .o_pc_addr(pc_addr),
        .o_pc(pc), .o_halt(halt));

endmodule

// ==== design/debug_unit.sv ====
`timescale 1ns/100ps

module debug_unit
    import debug_pkg::*;
(
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_rx_done,
    input  logic [BYTE_W-1:0]    i_rx_data,
    input  logic                 i_tx_done,
    input  logic                 i_tx_busy,
    input  logic                 i_halt,
    input  logic [WORD_W-1:0]    i_pc,
    input  logic [WORD_W-1:0]    i_instruction,
    output logic                 o_tx_start,
    output logic [BYTE_W-1:0]    o_tx_data,
    output logic                 o_im_write_enable,
    output logic [IM_ADDR_W-1:0] o_im_addr,
    output logic [WORD_W-1:0]    o_im_data,
    output logic                 o_step,
    output logic                 o_run,
    output logic                 o_pc_clear
);

    du_state_e             state;
    // shared by load and send, one word is four bytes
    logic [BYTE_CNT_W-1:0] byte_cnt;
    // next free word of the instruction memory
    logic [IM_ADDR_W-1:0]  load_ptr;
    // response word, shifted out lsb first
    logic [WORD_W-1:0]     send_word;

    logic last_byte;
    assign last_byte = (byte_cnt == BYTE_CNT_W'(WORD_BYTES - 1));

    // write address is the load pointer itself
    assign o_im_addr = load_ptr;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state             <= DU_IDLE;
            byte_cnt          <= '0;
            load_ptr          <= '0;
            o_tx_start        <= 1'b0;
            o_im_write_enable <= 1'b0;
            o_step            <= 1'b0;
            o_run             <= 1'b0;
            o_pc_clear        <= 1'b0;
        end else begin
            // strobes last one clock
            o_tx_start        <= 1'b0;
            o_im_write_enable <= 1'b0;
            o_step            <= 1'b0;
            o_pc_clear        <= 1'b0;
            // pointer moves past the word just written
            if (o_im_write_enable) begin
                load_ptr <= load_ptr + 1'b1;
            end
            case (state)
                DU_IDLE: begin
                    if (i_rx_done) begin
                        case (cmd_e'(i_rx_data))
                            CMD_LOAD: begin
                                state    <= DU_LOAD;
                                byte_cnt <= '0;
                            end
                            CMD_CLEAR: begin
                                o_pc_clear <= 1'b1;
                                load_ptr   <= '0;
                            end
                            CMD_STEP: o_step <= 1'b1;
                            CMD_RUN: begin
                                state <= DU_RUN;
                                o_run <= 1'b1;
                            end
                            CMD_PC: begin
                                send_word <= i_pc;
                                state     <= DU_SEND;
                            end
                            CMD_INSTR: begin
                                send_word <= i_instruction;
                                state     <= DU_SEND;
                            end
                            // unknown bytes are ignored
                            default: state <= DU_IDLE;
                        endcase
                    end
                end
                DU_LOAD: begin
                    if (i_rx_done) begin
                        // first byte ends up in the low lane
                        o_im_data <= {i_rx_data, o_im_data[WORD_W-1:BYTE_W]};
                        if (last_byte) begin
                            o_im_write_enable <= 1'b1;
                            byte_cnt          <= '0;
                            state             <= DU_IDLE;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                DU_RUN: begin
                    // fetch has stopped on the halt word
                    if (i_halt) begin
                        o_run     <= 1'b0;
                        send_word <= i_pc;
                        state     <= DU_SEND;
                    end
                end
                DU_SEND: begin
                    // first byte of a response
                    if (!i_tx_busy) begin
                        o_tx_start <= 1'b1;
                        o_tx_data  <= send_word[BYTE_W-1:0];
                        send_word  <= send_word >> BYTE_W;
                        byte_cnt   <= '0;
                        state      <= DU_WAIT_TX;
                    end
                end
                DU_WAIT_TX: begin
                    if (i_tx_done) begin
                        if (last_byte) begin
                            byte_cnt <= '0;
                            state    <= DU_IDLE;
                        end else begin
                            // next byte right behind the previous stop bit
                            o_tx_start <= 1'b1;
                            o_tx_data  <= send_word[BYTE_W-1:0];
                            send_word  <= send_word >> BYTE_W;
                            byte_cnt   <= byte_cnt + 1'b1;
                        end
                    end
                end
                default: state <= DU_IDLE;
            endcase
        end
    end

    // step and run never drive fetch together
    a_run_step_excl: assert property (@(posedge i_clock) disable iff (i_reset)
        !(o_run && o_step));

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit
    import debug_pkg::*;
(
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_pc_clear,
    input  logic                 i_step,
    input  logic                 i_run,
    input  logic [WORD_W-1:0]    i_instruction,
    output logic [IM_ADDR_W-1:0] o_pc_addr,
    output logic [WORD_W-1:0]    o_pc,
    output logic                 o_halt
);

    // word address, wraps at the memory depth
    logic [IM_ADDR_W-1:0] pc;

    // halt decode on the fetched word
    assign o_halt = (i_instruction == HALT_WORD);

    always_ff @(posedge i_clock) begin
        if (i_reset || i_pc_clear) begin
            pc <= '0;
        end else if (!o_halt && (i_step || i_run)) begin
            // one word per step pulse or per clock in run
            pc <= pc + 1'b1;
        end
    end

    assign o_pc_addr = pc;
    // zero extended for the host
    assign o_pc      = {{(WORD_W - IM_ADDR_W){1'b0}}, pc};

    // halt freezes fetch, only clear moves the pc
    a_halt_holds_pc: assert property (@(posedge i_clock) disable iff (i_reset)
        (o_halt && !i_pc_clear) |=> (pc == $past(pc)));

endmodule

// ==== design/instruction_memory.sv ====
`timescale 1ns/100ps

module instruction_memory
    import debug_pkg::*;
(
    input  logic                 i_clock,
    input  logic                 i_write_enable,
    input  logic [IM_ADDR_W-1:0] i_write_addr,
    input  logic [WORD_W-1:0]    i_write_data,
    input  logic [IM_ADDR_W-1:0] i_read_addr,
    output logic [WORD_W-1:0]    o_read_data
);

    // program storage, contents unknown after power up
    logic [WORD_W-1:0] mem [IM_DEPTH];

    // write port, loaded by the debug unit
    always_ff @(posedge i_clock) begin
        if (i_write_enable) begin
            mem[i_write_addr] <= i_write_data;
        end
    end

    // read port follows the pc in the same cycle
    assign o_read_data = mem[i_read_addr];

endmodule

// ==== design/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx
    import debug_pkg::*;
(
    input  logic              i_clock,
    input  logic              i_reset,
    input  logic              i_tick,
    input  logic              i_tx_start,
    input  logic [BYTE_W-1:0] i_tx_data,
    output logic              o_tx,
    output logic              o_tx_busy,
    output logic              o_tx_done
);

    tx_state_e            state;
    logic [OVS_CNT_W-1:0] tick_cnt;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [BYTE_W-1:0]    shift;

    // end of a bit period
    logic bit_end;
    assign bit_end = i_tick && (tick_cnt == OVS_CNT_W'(OVERSAMPLE - 1));

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state     <= TX_IDLE;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            o_tx      <= 1'b1;
            o_tx_done <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            if (i_tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                TX_IDLE: begin
                    if (i_tx_start) begin
                        // start bit goes out at once
                        state    <= TX_START;
                        shift    <= i_tx_data;
                        tick_cnt <= '0;
                        o_tx     <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state   <= TX_DATA;
                        bit_cnt <= '0;
                        o_tx    <= shift[0];
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == BIT_CNT_W'(BYTE_W - 1)) begin
                            // stop bit
                            state <= TX_STOP;
                            o_tx  <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            shift   <= shift >> 1;
                            o_tx    <= shift[1];
                        end
                    end
                end
                TX_STOP: begin
                    // done lands together with the return to idle
                    if (bit_end) begin
                        state     <= TX_IDLE;
                        o_tx_done <= 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    assign o_tx_busy = (state != TX_IDLE);

    // the debug unit must wait for a finished frame
    a_no_start_busy: assert property (@(posedge i_clock) disable iff (i_reset)
        i_tx_start |-> !o_tx_busy);

endmodule

// ==== design/uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx
    import debug_pkg::*;
(
    input  logic              i_clock,
    input  logic              i_reset,
    input  logic              i_tick,
    input  logic              i_rx,
    output logic [BYTE_W-1:0] o_rx_data,
    output logic              o_rx_done
);

    rx_state_e             state;
    // tick count inside a bit
    logic [OVS_CNT_W-1:0]  tick_cnt;
    // data bit index
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [BYTE_W-1:0]     shift;
    // two stage sync on the serial line
    logic                  rx_meta;
    logic                  rx_sync;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            // idle line is high
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state     <= RX_IDLE;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            o_rx_done <= 1'b0;
        end else begin
            o_rx_done <= 1'b0;
            case (state)
                RX_IDLE: begin
                    // falling edge starts a frame
                    if (!rx_sync) begin
                        state    <= RX_START;
                        tick_cnt <= '0;
                    end
                end
                RX_START: begin
                    if (i_tick) begin
                        if (tick_cnt == OVS_CNT_W'(OVERSAMPLE / 2 - 1)) begin
                            // mid start bit, glitch goes back to idle
                            state    <= rx_sync ? RX_IDLE : RX_DATA;
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                RX_DATA: begin
                    if (i_tick) begin
                        if (tick_cnt == OVS_CNT_W'(OVERSAMPLE - 1)) begin
                            tick_cnt <= '0;
                            // lsb first, shift in from the top
                            shift    <= {rx_sync, shift[BYTE_W-1:1]};
                            if (bit_cnt == BIT_CNT_W'(BYTE_W - 1)) begin
                                state <= RX_STOP;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    if (i_tick) begin
                        if (tick_cnt == OVS_CNT_W'(OVERSAMPLE - 1)) begin
                            state <= RX_IDLE;
                            // framing error drops the byte
                            if (rx_sync) begin
                                o_rx_done <= 1'b1;
                                o_rx_data <= shift;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // a byte is reported once
    a_rx_done_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
        o_rx_done |=> !o_rx_done);

endmodule

// ==== design/baud_rate_generator.sv ====
`timescale 1ns/100ps

module baud_rate_generator
    import debug_pkg::*;
(
    input  logic i_clock,
    input  logic i_reset,
    output logic o_tick
);

    // clocks inside one oversampling tick
    logic [TICK_CNT_W-1:0] count;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            count <= '0;
        end else if (count == TICK_CNT_W'(CLKS_PER_TICK - 1)) begin
            // wrap back to zero
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // one clock wide, shared by rx and tx
    assign o_tick = (count == TICK_CNT_W'(CLKS_PER_TICK - 1));

endmodule

// ==== design/debug_pkg.sv ====
package debug_pkg;

    // uart character and word sizes
    localparam int BYTE_W     = 8;
    localparam int WORD_W     = 32;
    localparam int WORD_BYTES = WORD_W / BYTE_W;
    localparam int BYTE_CNT_W = $clog2(WORD_BYTES);

    // instruction memory, 32 words
    localparam int IM_ADDR_W = 5;
    localparam int IM_DEPTH  = 1 << IM_ADDR_W;

    // baud timing, small values so a bit is 64 clocks in simulation
    localparam int CLKS_PER_TICK = 4;
    localparam int TICK_CNT_W    = $clog2(CLKS_PER_TICK);
    localparam int OVERSAMPLE    = 16;
    localparam int OVS_CNT_W     = $clog2(OVERSAMPLE);
    localparam int BIT_CNT_W     = $clog2(BYTE_W);

    // fetch stops on this word
    localparam logic [WORD_W-1:0] HALT_WORD = '1;

    // host command opcodes, ascii
    typedef enum logic [7:0] {
        CMD_LOAD  = 8'h4C,
        CMD_CLEAR = 8'h43,
        CMD_STEP  = 8'h53,
        CMD_RUN   = 8'h52,
        CMD_PC    = 8'h50,
        CMD_INSTR = 8'h49
    } cmd_e;

    typedef enum logic [2:0] {DU_IDLE, DU_LOAD, DU_RUN, DU_SEND, DU_WAIT_TX} du_state_e;

    // uart state machines
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

endpackage
